//--- src/gsm_cfg.svh
// configuration of the switch unit, shared by the packages and all RTL modules
// GSM_PORT_W and GSM_CELLS must follow GSM_PORTS and GSM_LADDR_W by hand
`ifndef GSM_CFG_SVH
`define GSM_CFG_SVH

// ------------------------------
// port and cell geometry
// ------------------------------

// ingress and egress port count
`define GSM_PORTS 4

// port index width
`define GSM_PORT_W 2

// bits per cell
`define GSM_DATA_W 32

// local address width and cells per port partition
`define GSM_LADDR_W 3
`define GSM_CELLS 8

// egress pointer queue, deep enough for every cell of every port
`define GSM_EQ_DEPTH 32
`define GSM_EQ_AW 5

`endif

//--- src/gsm_cell_pkg.sv
// vector types for cells and addresses of the central memory
// a global address is the owning port index above the local address
`include "gsm_cfg.svh"

package gsm_cell_pkg;

	// ------------------------------
	// payload
	// ------------------------------

	// one data cell
	typedef logic [`GSM_DATA_W-1:0] cell_data_t;

	// ------------------------------
	// addressing
	// ------------------------------

	// cell address inside one port partition
	typedef logic [`GSM_LADDR_W-1:0] laddr_t;

	// {port, local address}, addresses the central RAM
	typedef logic [`GSM_PORT_W+`GSM_LADDR_W-1:0] gaddr_t;

	// ------------------------------
	// per-port vectors and counts
	// ------------------------------

	// multicast mask, or one bit per port
	typedef logic [`GSM_PORTS-1:0] port_mask_t;

	// egress reads still pending on a cell, up to GSM_PORTS
	typedef logic [`GSM_PORT_W:0] refcnt_t;

endpackage

//--- src/gsm_port_pkg.sv
// request and write records passed between the ingress side and the cell store
package gsm_port_pkg;

	import gsm_cell_pkg::*;

	// ------------------------------
	// ingress side
	// ------------------------------

	// one port's write request, laddr comes from its malloc
	typedef struct packed {
		laddr_t     laddr;
		port_mask_t mask;
		cell_data_t data;
	} wr_req_t;

	// ------------------------------
	// memory side
	// ------------------------------

	// granted write, owning port already merged into addr
	typedef struct packed {
		logic       valid;
		gaddr_t     addr;
		port_mask_t mask;
		cell_data_t data;
	} mem_wr_t;

endpackage

//--- src/gsm_ingress_sched.sv
// one ingress write per cycle, granted by a slot that rotates whether or not the
// port is busy, so a port may wait up to GSM_PORTS cycles for its ready
`include "gsm_cfg.svh"

module gsm_ingress_sched (
	input  logic                     clk_320M,
	input  logic                     i_reset,
	input  gsm_cell_pkg::port_mask_t i_wr_valid,
	input  gsm_port_pkg::wr_req_t    i_wr_req [`GSM_PORTS],
	output gsm_cell_pkg::port_mask_t o_wr_ready,
	output gsm_port_pkg::mem_wr_t    o_mem_wr
);

	import gsm_cell_pkg::*;
	import gsm_port_pkg::*;

	port_mask_t             slot;
	logic [`GSM_PORT_W-1:0] slot_idx;
	wr_req_t                req_sel;
	logic                   accept;

	// ------------------------------
	// slot rotation
	// ------------------------------

	// empty right after reset so no ready is shown, token then starts at port 0
	always_ff @(posedge clk_320M) begin
		if (i_reset) begin
			slot <= '0;
		end else if (slot == '0) begin
			slot <= port_mask_t'(1);
		end else begin
			slot <= {slot[`GSM_PORTS-2:0], slot[`GSM_PORTS-1]};
		end
	end

	// one-hot to index
	always_comb begin
		slot_idx = '0;
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (slot[p]) begin
				slot_idx = `GSM_PORT_W'(p);
			end
		end
	end

	assign o_wr_ready = slot;

	// ------------------------------
	// grant register
	// ------------------------------

	assign req_sel = i_wr_req[slot_idx];
	assign accept  = |(i_wr_valid & slot);

	// write reaches the cell store one cycle after the handshake
	always_ff @(posedge clk_320M) begin
		if (accept) begin
			o_mem_wr.addr <= {slot_idx, req_sel.laddr};
			o_mem_wr.mask <= req_sel.mask;
			o_mem_wr.data <= req_sel.data;
		end
		if (i_reset) begin
			o_mem_wr.valid <= 1'b0;
		end else begin
			o_mem_wr.valid <= accept;
		end
	end

endmodule

//--- src/gsm_free_list.sv
// free cell pointers, one circular queue per port inside a shared pointer RAM
// queues are filled for GSM_PORTS*GSM_CELLS cycles after reset; releases must not
// arrive during that fill, and no partition ever holds more than GSM_CELLS entries
`include "gsm_cfg.svh"

module gsm_free_list (
	input  logic                     clk_320M,
	input  logic                     i_reset,
	input  logic                     i_rel_valid,
	input  gsm_cell_pkg::gaddr_t     i_rel_addr,
	output gsm_cell_pkg::port_mask_t o_hmp_valid,
	output gsm_cell_pkg::laddr_t     o_hmp_addr [`GSM_PORTS],
	input  gsm_cell_pkg::port_mask_t i_hmp_rd
);

	import gsm_cell_pkg::*;

	typedef enum logic {FILL, RUN} fill_state_t;

	fill_state_t            state;
	gaddr_t                 fill_addr;
	laddr_t                 ptr_ram [`GSM_PORTS*`GSM_CELLS];
	laddr_t                 rd_ptr [`GSM_PORTS];
	laddr_t                 wr_ptr [`GSM_PORTS];
	logic [`GSM_LADDR_W:0]  count [`GSM_PORTS];
	logic                   wr_en;
	gaddr_t                 wr_cell;
	logic [`GSM_PORT_W-1:0] wr_port;
	port_mask_t             wr_sel;
	port_mask_t             rf_sel;
	logic [`GSM_PORT_W-1:0] rf_idx;
	port_mask_t             rd_issue;
	port_mask_t             rd_pend;
	laddr_t                 rd_data;

	// ------------------------------
	// reset fill
	// ------------------------------

	always_ff @(posedge clk_320M) begin
		if (i_reset) begin
			state     <= FILL;
			fill_addr <= '0;
		end else if (state == FILL) begin
			fill_addr <= fill_addr + 1'b1;
			if (fill_addr == '1) begin
				state <= RUN;
			end
		end
	end

	// fill and release share the single write path
	always_comb begin
		if (state == FILL) begin
			wr_en   = 1'b1;
			wr_cell = fill_addr;
		end else begin
			wr_en   = i_rel_valid;
			wr_cell = i_rel_addr;
		end
		wr_port = wr_cell[`GSM_PORT_W+`GSM_LADDR_W-1:`GSM_LADDR_W];
		for (int p = 0; p < `GSM_PORTS; p++) begin
			wr_sel[p] = wr_en && (wr_port == `GSM_PORT_W'(p));
		end
	end

	always_ff @(posedge clk_320M) begin
		if (wr_en) begin
			ptr_ram[{wr_port, wr_ptr[wr_port]}] <= wr_cell[`GSM_LADDR_W-1:0];
		end
		if (|rd_issue) begin
			rd_data <= ptr_ram[{rf_idx, rd_ptr[rf_idx]}];
		end
	end

	// ------------------------------
	// queue pointers
	// ------------------------------

	always_ff @(posedge clk_320M) begin
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (i_reset) begin
				rd_ptr[p] <= '0;
				wr_ptr[p] <= '0;
				count[p]  <= '0;
			end else begin
				if (wr_sel[p]) begin
					wr_ptr[p] <= wr_ptr[p] + 1'b1;
				end
				if (rd_issue[p]) begin
					rd_ptr[p] <= rd_ptr[p] + 1'b1;
				end
				case ({wr_sel[p], rd_issue[p]})
					2'b10: count[p] <= count[p] + 1'b1;
					2'b01: count[p] <= count[p] - 1'b1;
					default: ;
				endcase
			end
		end
	end

	// ------------------------------
	// prefetch refill, one port per cycle
	// ------------------------------

	always_ff @(posedge clk_320M) begin
		if (i_reset) begin
			rf_sel <= port_mask_t'(1);
		end else begin
			rf_sel <= {rf_sel[`GSM_PORTS-2:0], rf_sel[`GSM_PORTS-1]};
		end
	end

	always_comb begin
		rf_idx = '0;
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (rf_sel[p]) begin
				rf_idx = `GSM_PORT_W'(p);
			end
			rd_issue[p] = (state == RUN) && rf_sel[p] && (count[p] != '0)
				&& !o_hmp_valid[p] && !rd_pend[p];
		end
	end

	// pointer lands in the malloc register the cycle after the RAM read
	always_ff @(posedge clk_320M) begin
		if (i_reset) begin
			rd_pend     <= '0;
			o_hmp_valid <= '0;
		end else begin
			rd_pend <= rd_issue;
			for (int p = 0; p < `GSM_PORTS; p++) begin
				if (rd_pend[p]) begin
					o_hmp_valid[p] <= 1'b1;
				end else if (i_hmp_rd[p]) begin
					o_hmp_valid[p] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_320M) begin
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (rd_pend[p]) begin
				o_hmp_addr[p] <= rd_data;
			end
		end
	end

endmodule

//--- src/gsm_cell_store.sv
// central cell RAM with reference counts and one pointer queue per egress port
// a write must not hit a cell that still has egress reads pending
`include "gsm_cfg.svh"

module gsm_cell_store (
	input  logic                     clk_320M,
	input  logic                     i_reset,
	input  gsm_port_pkg::mem_wr_t    i_mem_wr,
	output gsm_cell_pkg::port_mask_t o_eg_valid,
	output gsm_cell_pkg::cell_data_t o_eg_data [`GSM_PORTS],
	input  gsm_cell_pkg::port_mask_t i_eg_ready,
	output logic                     o_rel_valid,
	output gsm_cell_pkg::gaddr_t     o_rel_addr
);

	import gsm_cell_pkg::*;

	cell_data_t             cell_ram [`GSM_PORTS*`GSM_CELLS];
	refcnt_t                refcnt [`GSM_PORTS*`GSM_CELLS];
	gaddr_t                 eq_mem [`GSM_PORTS][`GSM_EQ_DEPTH];
	logic [`GSM_EQ_AW-1:0]  eq_wr_ptr [`GSM_PORTS];
	logic [`GSM_EQ_AW-1:0]  eq_rd_ptr [`GSM_PORTS];
	logic [`GSM_EQ_AW:0]    eq_cnt [`GSM_PORTS];
	port_mask_t             eq_push;
	port_mask_t             eg_slot;
	port_mask_t             eg_grant;
	logic [`GSM_PORT_W-1:0] eg_idx;
	gaddr_t                 rd_gaddr;
	logic                   wr_cell;
	logic                   zero_wr;
	logic                   last_read;

	// number of set bits in a multicast mask
	function automatic refcnt_t mask_count(input port_mask_t m);
		refcnt_t n;
		n = '0;
		for (int p = 0; p < `GSM_PORTS; p++) begin
			n = n + refcnt_t'(m[p]);
		end
		return n;
	endfunction

	// ------------------------------
	// write side
	// ------------------------------

	assign wr_cell = i_mem_wr.valid && (i_mem_wr.mask != '0);
	assign zero_wr = i_mem_wr.valid && (i_mem_wr.mask == '0);
	assign eq_push = i_mem_wr.valid ? i_mem_wr.mask : '0;

	// a write to the same cell overrides the decrement
	always_ff @(posedge clk_320M) begin
		if (|eg_grant) begin
			refcnt[rd_gaddr] <= refcnt[rd_gaddr] - 1'b1;
		end
		if (wr_cell) begin
			cell_ram[i_mem_wr.addr] <= i_mem_wr.data;
			refcnt[i_mem_wr.addr]   <= mask_count(i_mem_wr.mask);
		end
	end

	// ------------------------------
	// egress pointer queues
	// ------------------------------

	always_ff @(posedge clk_320M) begin
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (eq_push[p]) begin
				eq_mem[p][eq_wr_ptr[p]] <= i_mem_wr.addr;
			end
		end
	end

	always_ff @(posedge clk_320M) begin
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (i_reset) begin
				eq_wr_ptr[p] <= '0;
				eq_rd_ptr[p] <= '0;
				eq_cnt[p]    <= '0;
			end else begin
				if (eq_push[p]) begin
					eq_wr_ptr[p] <= eq_wr_ptr[p] + 1'b1;
				end
				if (eg_grant[p]) begin
					eq_rd_ptr[p] <= eq_rd_ptr[p] + 1'b1;
				end
				case ({eq_push[p], eg_grant[p]})
					2'b10: eq_cnt[p] <= eq_cnt[p] + 1'b1;
					2'b01: eq_cnt[p] <= eq_cnt[p] - 1'b1;
					default: ;
				endcase
			end
		end
	end

	// ------------------------------
	// egress read scheduler
	// ------------------------------

	always_ff @(posedge clk_320M) begin
		if (i_reset) begin
			eg_slot <= port_mask_t'(1);
		end else begin
			eg_slot <= {eg_slot[`GSM_PORTS-2:0], eg_slot[`GSM_PORTS-1]};
		end
	end

	// a zero-mask write holds off reads so only one release is due per cycle
	always_comb begin
		eg_idx = '0;
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (eg_slot[p]) begin
				eg_idx = `GSM_PORT_W'(p);
			end
			eg_grant[p] = eg_slot[p] && (eq_cnt[p] != '0)
				&& (!o_eg_valid[p] || i_eg_ready[p]) && !zero_wr;
		end
		rd_gaddr  = eq_mem[eg_idx][eq_rd_ptr[eg_idx]];
		last_read = (|eg_grant) && (refcnt[rd_gaddr] == refcnt_t'(1));
	end

	// output register only reloads when empty or being taken
	always_ff @(posedge clk_320M) begin
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (i_reset) begin
				o_eg_valid[p] <= 1'b0;
			end else if (eg_grant[p]) begin
				o_eg_valid[p] <= 1'b1;
			end else if (i_eg_ready[p]) begin
				o_eg_valid[p] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_320M) begin
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (eg_grant[p]) begin
				o_eg_data[p] <= cell_ram[rd_gaddr];
			end
		end
	end

	// ------------------------------
	// cell release
	// ------------------------------

	always_ff @(posedge clk_320M) begin
		if (zero_wr) begin
			o_rel_addr <= i_mem_wr.addr;
		end else if (last_read) begin
			o_rel_addr <= rd_gaddr;
		end
		if (i_reset) begin
			o_rel_valid <= 1'b0;
		end else begin
			o_rel_valid <= zero_wr || last_read;
		end
	end

endmodule

//--- src/gsm_unit.sv
// grouped shared memory switch unit, single clock
// a port writes only a local address it took from its own malloc port
`include "gsm_cfg.svh"

module gsm_unit (
	input  logic                     clk_320M,
	input  logic                     i_reset,

	// malloc
	output gsm_cell_pkg::port_mask_t o_hmp_valid,
	output gsm_cell_pkg::laddr_t     o_hmp_addr [`GSM_PORTS],
	input  gsm_cell_pkg::port_mask_t i_hmp_rd,

	// ingress
	input  gsm_cell_pkg::port_mask_t i_wr_valid,
	input  gsm_port_pkg::wr_req_t    i_wr_req [`GSM_PORTS],
	output gsm_cell_pkg::port_mask_t o_wr_ready,

	// egress
	output gsm_cell_pkg::port_mask_t o_eg_valid,
	output gsm_cell_pkg::cell_data_t o_eg_data [`GSM_PORTS],
	input  gsm_cell_pkg::port_mask_t i_eg_ready
);

	import gsm_cell_pkg::*;
	import gsm_port_pkg::*;

	mem_wr_t mem_wr;
	logic    rel_valid;
	gaddr_t  rel_addr;

	// ------------------------------
	// ingress slots into the store
	// ------------------------------

	gsm_ingress_sched u_sched (
		.clk_320M   (clk_320M),
		.i_reset    (i_reset),
		.i_wr_valid (i_wr_valid),
		.i_wr_req   (i_wr_req),
		.o_wr_ready (o_wr_ready),
		.o_mem_wr   (mem_wr)
	);

	gsm_cell_store u_store (
		.clk_320M    (clk_320M),
		.i_reset     (i_reset),
		.i_mem_wr    (mem_wr),
		.o_eg_valid  (o_eg_valid),
		.o_eg_data   (o_eg_data),
		.i_eg_ready  (i_eg_ready),
		.o_rel_valid (rel_valid),
		.o_rel_addr  (rel_addr)
	);

	// released cells go back to the owner's free queue
	gsm_free_list u_free (
		.clk_320M    (clk_320M),
		.i_reset     (i_reset),
		.i_rel_valid (rel_valid),
		.i_rel_addr  (rel_addr),
		.o_hmp_valid (o_hmp_valid),
		.o_hmp_addr  (o_hmp_addr),
		.i_hmp_rd    (i_hmp_rd)
	);

endmodule

//--- sim/gsm_unit_properties.sv
// checker bound into gsm_unit, keeps an expected FIFO per egress port
// model FIFOs hold 64 cells per port, far more than the 32 cells of the RAM
`include "gsm_cfg.svh"

module gsm_unit_properties (
	input  logic                     clk_320M,
	input  logic                     i_reset,
	input  gsm_cell_pkg::port_mask_t o_hmp_valid,
	input  gsm_cell_pkg::laddr_t     o_hmp_addr [`GSM_PORTS],
	input  gsm_cell_pkg::port_mask_t i_hmp_rd,
	input  gsm_cell_pkg::port_mask_t i_wr_valid,
	input  gsm_port_pkg::wr_req_t    i_wr_req [`GSM_PORTS],
	input  gsm_cell_pkg::port_mask_t o_wr_ready,
	input  gsm_port_pkg::mem_wr_t    i_mem_wr,
	input  gsm_cell_pkg::port_mask_t o_eg_valid,
	input  gsm_cell_pkg::cell_data_t o_eg_data [`GSM_PORTS],
	input  gsm_cell_pkg::port_mask_t i_eg_ready
);

	timeunit 1ns;
	timeprecision 1ps;

	import gsm_cell_pkg::*;
	import gsm_port_pkg::*;

	localparam int DEPTH = 64;
	localparam int FILL = `GSM_PORTS * `GSM_CELLS;

	cell_data_t             exp_mem [`GSM_PORTS][DEPTH];
	int                     exp_wr [`GSM_PORTS];
	int                     exp_rd [`GSM_PORTS];
	int                     exp_cnt [`GSM_PORTS];
	cell_data_t             exp_head [`GSM_PORTS];
	int                     exp_pending;
	int                     hmp_taken [`GSM_PORTS];
	laddr_t                 hmp_addr_q [`GSM_PORTS];
	cell_data_t             eg_data_q [`GSM_PORTS];
	int                     fill_cycles;
	int                     fail_count = 0;
	logic                   reset_q;
	port_mask_t             wr_acc;
	logic [`GSM_PORT_W-1:0] acc_idx;
	wr_req_t                acc_req;
	gaddr_t                 acc_gaddr_q;

	// ------------------------------
	// reference model
	// ------------------------------

	always_comb begin
		wr_acc = i_wr_valid & o_wr_ready;
		acc_idx = '0;
		for (int p = 0; p < `GSM_PORTS; p++) begin
			if (wr_acc[p]) begin
				acc_idx = `GSM_PORT_W'(p);
			end
		end
		acc_req = i_wr_req[acc_idx];
		exp_pending = 0;
		for (int q = 0; q < `GSM_PORTS; q++) begin
			exp_cnt[q] = exp_wr[q] - exp_rd[q];
			exp_head[q] = exp_mem[q][exp_rd[q] % DEPTH];
			exp_pending = exp_pending + exp_cnt[q];
		end
	end

	// one copy per masked egress port, in acceptance order
	always_ff @(posedge clk_320M) begin
		reset_q <= i_reset;
		acc_gaddr_q <= {acc_idx, acc_req.laddr};
		for (int q = 0; q < `GSM_PORTS; q++) begin
			hmp_addr_q[q] <= o_hmp_addr[q];
			eg_data_q[q] <= o_eg_data[q];
		end
		if (i_reset) begin
			fill_cycles <= 0;
			for (int q = 0; q < `GSM_PORTS; q++) begin
				exp_wr[q] <= 0;
				exp_rd[q] <= 0;
				hmp_taken[q] <= 0;
			end
		end else begin
			if (fill_cycles < FILL) begin
				fill_cycles <= fill_cycles + 1;
			end
			for (int q = 0; q < `GSM_PORTS; q++) begin
				if ((|wr_acc) && acc_req.mask[q]) begin
					exp_mem[q][exp_wr[q] % DEPTH] <= acc_req.data;
					exp_wr[q] <= exp_wr[q] + 1;
				end
				if (o_eg_valid[q] && i_eg_ready[q]) begin
					exp_rd[q] <= exp_rd[q] + 1;
				end
				if (o_hmp_valid[q] && i_hmp_rd[q]) begin
					hmp_taken[q] <= hmp_taken[q] + 1;
				end
			end
		end
	end

	// ------------------------------
	// unit-wide checks
	// ------------------------------

	reset_low: assert property (@(posedge clk_320M)
		reset_q |-> (o_hmp_valid == '0 && o_wr_ready == '0 && o_eg_valid == '0))
		else begin
			fail_count = fail_count + 1;
			$error("CHECK FAILED reset outputs got hmp %h wr %h eg %h expected 0",
				$sampled(o_hmp_valid), $sampled(o_wr_ready), $sampled(o_eg_valid));
		end

	fill_quiet: assert property (@(posedge clk_320M) disable iff (i_reset)
		fill_cycles < FILL |-> o_hmp_valid == '0)
		else begin
			fail_count = fail_count + 1;
			$error("CHECK FAILED o_hmp_valid got %h expected 0 during fill",
				$sampled(o_hmp_valid));
		end

	one_ready: assert property (@(posedge clk_320M) disable iff (i_reset)
		$onehot0(o_wr_ready))
		else begin
			fail_count = fail_count + 1;
			$error("CHECK FAILED o_wr_ready got %h expected at most one bit",
				$sampled(o_wr_ready));
		end

	// granted write carries the accepting port above the local address
	grant_addr: assert property (@(posedge clk_320M) disable iff (i_reset)
		(|wr_acc) |=> (i_mem_wr.valid && i_mem_wr.addr == acc_gaddr_q))
		else begin
			fail_count = fail_count + 1;
			$error("CHECK FAILED mem_wr.addr got %h expected %h",
				$sampled(i_mem_wr.addr), $sampled(acc_gaddr_q));
		end

	// ------------------------------
	// per-port checks
	// ------------------------------

	generate
		for (genvar p = 0; p < `GSM_PORTS; p++) begin : g_port
			// first round of pointers comes straight from the fill
			first_ptrs: assert property (@(posedge clk_320M) disable iff (i_reset)
				(o_hmp_valid[p] && hmp_taken[p] < `GSM_CELLS)
				|-> o_hmp_addr[p] == laddr_t'(hmp_taken[p]))
				else begin
					fail_count = fail_count + 1;
					$error("CHECK FAILED o_hmp_addr[%0d] got %h expected %h",
						p, $sampled(o_hmp_addr[p]), $sampled(hmp_taken[p]));
				end

			malloc_hold: assert property (@(posedge clk_320M) disable iff (i_reset)
				(o_hmp_valid[p] && !i_hmp_rd[p])
				|=> (o_hmp_valid[p] && o_hmp_addr[p] == hmp_addr_q[p]))
				else begin
					fail_count = fail_count + 1;
					$error("CHECK FAILED o_hmp_addr[%0d] got %h expected %h valid %h",
						p, $sampled(o_hmp_addr[p]), $sampled(hmp_addr_q[p]),
						$sampled(o_hmp_valid[p]));
				end

			eg_hold: assert property (@(posedge clk_320M) disable iff (i_reset)
				(o_eg_valid[p] && !i_eg_ready[p])
				|=> (o_eg_valid[p] && o_eg_data[p] == eg_data_q[p]))
				else begin
					fail_count = fail_count + 1;
					$error("CHECK FAILED o_eg_data[%0d] got %h expected %h valid %h",
						p, $sampled(o_eg_data[p]), $sampled(eg_data_q[p]),
						$sampled(o_eg_valid[p]));
				end

			eg_order: assert property (@(posedge clk_320M) disable iff (i_reset)
				(o_eg_valid[p] && i_eg_ready[p])
				|-> (exp_cnt[p] != 0 && o_eg_data[p] == exp_head[p]))
				else begin
					fail_count = fail_count + 1;
					$error("CHECK FAILED o_eg_data[%0d] got %h expected %h pending %h",
						p, $sampled(o_eg_data[p]), $sampled(exp_head[p]),
						$sampled(exp_cnt[p]));
				end
		end
	endgenerate

endmodule

bind gsm_unit gsm_unit_properties u_props (
	.clk_320M    (clk_320M),
	.i_reset     (i_reset),
	.o_hmp_valid (o_hmp_valid),
	.o_hmp_addr  (o_hmp_addr),
	.i_hmp_rd    (i_hmp_rd),
	.i_wr_valid  (i_wr_valid),
	.i_wr_req    (i_wr_req),
	.o_wr_ready  (o_wr_ready),
	.i_mem_wr    (mem_wr),
	.o_eg_valid  (o_eg_valid),
	.o_eg_data   (o_eg_data),
	.i_eg_ready  (i_eg_ready)
);

//--- sim/gsm_unit_tb.sv
// random multicast traffic, then a full egress drain and a recount of all pointers
// the bound checker holds the per-cycle checks, this file checks the end state
`include "gsm_cfg.svh"

module gsm_unit_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import gsm_cell_pkg::*;
	import gsm_port_pkg::*;

	localparam int NUM_CELLS = 120;
	localparam int RESET_CYCLES = 10;
	localparam int FILL_CYCLES = `GSM_PORTS * `GSM_CELLS;
	localparam int MAX_CYCLES = 20 * NUM_CELLS + FILL_CYCLES;

	logic        clk_320M;
	logic        i_reset;
	port_mask_t  o_hmp_valid;
	laddr_t      o_hmp_addr [`GSM_PORTS];
	port_mask_t  i_hmp_rd;
	port_mask_t  i_wr_valid;
	wr_req_t     i_wr_req [`GSM_PORTS];
	port_mask_t  o_wr_ready;
	port_mask_t  o_eg_valid;
	cell_data_t  o_eg_data [`GSM_PORTS];
	port_mask_t  i_eg_ready;

	logic [31:0] rng_state;
	int          cycles;
	int          tb_errors;
	int          reserved;
	int          sent;
	int          seq;
	port_mask_t  have_ptr;
	laddr_t      held_addr [`GSM_PORTS];

	gsm_unit uut (
		.clk_320M    (clk_320M),
		.i_reset     (i_reset),
		.o_hmp_valid (o_hmp_valid),
		.o_hmp_addr  (o_hmp_addr),
		.i_hmp_rd    (i_hmp_rd),
		.i_wr_valid  (i_wr_valid),
		.i_wr_req    (i_wr_req),
		.o_wr_ready  (o_wr_ready),
		.o_eg_valid  (o_eg_valid),
		.o_eg_data   (o_eg_data),
		.i_eg_ready  (i_eg_ready)
	);

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		clk_320M = 1'b0;
		forever #4 clk_320M = ~clk_320M;
	end

	always @(posedge clk_320M) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ------------------------------
	// per-port ingress sequence
	// ------------------------------

	// malloc a pointer, then write one cell into it
	task automatic step_port(input int p);
		logic    wr_busy;
		wr_req_t req;
		wr_busy = i_wr_valid[p];
		if (i_wr_valid[p] && o_wr_ready[p]) begin
			i_wr_valid[p] <= 1'b0;
			wr_busy = 1'b0;
			sent++;
		end
		if (i_hmp_rd[p] && o_hmp_valid[p]) begin
			held_addr[p] = o_hmp_addr[p];
			have_ptr[p] = 1'b1;
			i_hmp_rd[p] <= 1'b0;
		end
		rng_state = xorshift32(rng_state);
		if (have_ptr[p] && !wr_busy) begin
			// data is {source port, sequence number, local address}
			req.laddr = held_addr[p];
			req.mask = port_mask_t'(rng_state[`GSM_PORTS-1:0]);
			req.data = cell_data_t'({8'(p), 16'(seq), 8'(held_addr[p])});
			seq++;
			have_ptr[p] = 1'b0;
			i_wr_valid[p] <= 1'b1;
			i_wr_req[p] <= req;
		end else if (!have_ptr[p] && !wr_busy && !i_hmp_rd[p] && rng_state[8]
			&& reserved < NUM_CELLS) begin
			i_hmp_rd[p] <= 1'b1;
			reserved++;
		end
	endtask

	task automatic run_traffic();
		while (sent < NUM_CELLS) begin
			@(posedge clk_320M);
			for (int p = 0; p < `GSM_PORTS; p++) begin
				step_port(p);
			end
			rng_state = xorshift32(rng_state);
			i_eg_ready <= port_mask_t'(rng_state[`GSM_PORTS-1:0]);
		end
	endtask

	// ------------------------------
	// drain and recount
	// ------------------------------

	task automatic drain_egress();
		int idle;
		idle = 0;
		i_eg_ready <= '1;
		while (idle < 16) begin
			@(posedge clk_320M);
			idle = (o_eg_valid == '0) ? idle + 1 : 0;
		end
		assert (uut.u_props.exp_pending == 0) else begin
			tb_errors++;
			$display("CHECK FAILED exp_pending got %h expected %h",
				uut.u_props.exp_pending, 0);
		end
	endtask

	task automatic recount_pointers();
		int                    got [`GSM_PORTS];
		logic [`GSM_CELLS-1:0] seen [`GSM_PORTS];
		int                    waited;
		logic                  done;
		for (int p = 0; p < `GSM_PORTS; p++) begin
			got[p] = 0;
			seen[p] = '0;
		end
		i_hmp_rd <= '1;
		waited = 0;
		done = 1'b0;
		while (!done && waited < 8 * FILL_CYCLES) begin
			@(posedge clk_320M);
			waited++;
			done = 1'b1;
			for (int p = 0; p < `GSM_PORTS; p++) begin
				if (i_hmp_rd[p] && o_hmp_valid[p]) begin
					seen[p][o_hmp_addr[p]] = 1'b1;
					got[p]++;
					if (got[p] == `GSM_CELLS) begin
						i_hmp_rd[p] <= 1'b0;
					end
				end
				if (got[p] < `GSM_CELLS) begin
					done = 1'b0;
				end
			end
		end
		// a ninth pointer would show up within a few refill rounds
		repeat (16) @(posedge clk_320M);
		for (int p = 0; p < `GSM_PORTS; p++) begin
			assert (got[p] == `GSM_CELLS && seen[p] == '1) else begin
				tb_errors++;
				$display("CHECK FAILED malloc port %0d count %h seen %h expected %h %h",
					p, got[p], seen[p], `GSM_CELLS, {`GSM_CELLS{1'b1}});
			end
			assert (!o_hmp_valid[p]) else begin
				tb_errors++;
				$display("port %0d offers more pointers than its partition holds", p);
			end
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		i_reset = 1'b1;
		i_hmp_rd = '0;
		i_wr_valid = '0;
		i_eg_ready = '0;
		for (int p = 0; p < `GSM_PORTS; p++) begin
			i_wr_req[p] = '0;
			held_addr[p] = '0;
		end
		rng_state = 32'd95793;
		cycles = 0;
		tb_errors = 0;
		reserved = 0;
		sent = 0;
		seq = 0;
		have_ptr = '0;
		repeat (RESET_CYCLES) @(posedge clk_320M);
		i_reset <= 1'b0;
		run_traffic();
		drain_egress();
		recount_pointers();
		$display("errors: %0d assertion failures, %0d end-state failures, %0d cells sent",
			uut.u_props.fail_count, tb_errors, sent);
		if (uut.u_props.fail_count == 0 && tb_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+src
src/gsm_cell_pkg.sv
src/gsm_port_pkg.sv
src/gsm_ingress_sched.sv
src/gsm_free_list.sv
src/gsm_cell_store.sv
src/gsm_unit.sv
sim/gsm_unit_properties.sv
sim/gsm_unit_tb.sv

//--- Makefile
# Verilator lint and simulation of the switch unit testbench

VERILATOR ?= verilator
TOP       ?= gsm_unit_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
BFLAGS    ?= -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) $(BFLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
